// ==== hdl/stb_pkg.sv ====
// store path shared definitions
`default_nettype none

package stb_pkg;

    // physical byte address width
    localparam int PHYS_BITS = 32;

    // word address drops the two byte-offset bits
    localparam int WORD_ADDR_BITS = PHYS_BITS - 2;

    // store buffer depth
    localparam int SB_ENTRIES = 8;

    // reorder buffer tag width
    localparam int ROB_TAG_BITS = 5;

    // low word address bits used by the cache array model, 64 words
    localparam int MEM_INDEX_BITS = 6;

    // store size opcode from the store unit
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } store_size_e;

    // drain side of the four-phase req/ack handshake
    typedef enum logic [1:0] {
        // no request outstanding
        DR_IDLE         = 2'd0,
        // req up, waiting for the write port
        DR_WAIT_ACK     = 2'd1,
        // req dropped, waiting for ack to fall
        DR_WAIT_RELEASE = 2'd2
    } drain_state_e;

endpackage

`default_nettype wire

// ==== hdl/store_issue.sv ====
// store issue stage
`timescale 1ns/100ps
`default_nettype none

module store_issue (
    input  wire logic                                cpu_clk_i,
    input  wire logic                                reset_i,
    input  wire logic                                flush_i,
    // issue side
    input  wire logic                                st_valid_i,
    input  wire logic [stb_pkg::PHYS_BITS-1:0]       st_addr_i,
    input  wire stb_pkg::store_size_e                st_size_i,
    input  wire logic [31:0]                         st_data_i,
    input  wire logic                                st_io_i,
    input  wire logic [stb_pkg::ROB_TAG_BITS-1:0]    st_rob_i,
    output logic                                     st_ready_o,
    output logic                                     st_fault_o,
    // enqueue link to the store buffer
    input  wire logic                                enq_full_i,
    output logic                                     enq_en_o,
    output logic [stb_pkg::WORD_ADDR_BITS-1:0]       enq_addr_o,
    output logic [31:0]                              enq_data_o,
    output logic [3:0]                               enq_bm_o,
    output logic                                     enq_io_o,
    output logic [stb_pkg::ROB_TAG_BITS-1:0]         enq_rob_o
);
    logic        hold_vld;
    logic [3:0]  bm;
    logic [31:0] lane_data;
    logic        misaligned;
    logic        accept;

    // size and offset decode
    always_comb begin
        case (st_size_i)
            stb_pkg::SZ_BYTE: begin
                bm         = 4'b0001 << st_addr_i[1:0];
                lane_data  = {4{st_data_i[7:0]}};
                misaligned = 1'b0;
            end
            stb_pkg::SZ_HALF: begin
                bm         = st_addr_i[1] ? 4'b1100 : 4'b0011;
                lane_data  = {2{st_data_i[15:0]}};
                misaligned = st_addr_i[0];
            end
            // word, and the unused encoding treated the same way
            default: begin
                bm         = 4'b1111;
                lane_data  = st_data_i;
                misaligned = |st_addr_i[1:0];
            end
        endcase
    end

    // room when empty, or the held store leaves this cycle
    assign st_ready_o = !hold_vld || !enq_full_i;
    assign accept     = st_valid_i && st_ready_o;
    // held store never reaches the link in a flush cycle
    assign enq_en_o   = hold_vld && !flush_i;

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            hold_vld   <= 1'b0;
            st_fault_o <= 1'b0;
        end else begin
            // one-cycle fault pulse, faulting store never held
            st_fault_o <= accept && misaligned;
            if (flush_i) begin
                hold_vld <= 1'b0;
            end else if (accept) begin
                hold_vld <= !misaligned;
            end else if (!enq_full_i) begin
                hold_vld <= 1'b0;
            end
        end
    end

    // payload only loads on a good accept
    always_ff @(posedge cpu_clk_i) begin
        if (accept && !misaligned) begin
            enq_addr_o <= st_addr_i[stb_pkg::PHYS_BITS-1:2];
            enq_data_o <= lane_data;
            enq_bm_o   <= bm;
            enq_io_o   <= st_io_i;
            enq_rob_o  <= st_rob_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/store_buffer.sv ====
// speculative store buffer
`timescale 1ns/100ps
`default_nettype none

module store_buffer (
    input  wire logic                                cpu_clk_i,
    input  wire logic                                reset_i,
    input  wire logic                                flush_i,
    // enqueue
    input  wire logic                                enq_en_i,
    input  wire logic [stb_pkg::WORD_ADDR_BITS-1:0]  enq_addr_i,
    input  wire logic [31:0]                         enq_data_i,
    input  wire logic [3:0]                          enq_bm_i,
    input  wire logic                                enq_io_i,
    input  wire logic [stb_pkg::ROB_TAG_BITS-1:0]    enq_rob_i,
    output logic                                     enq_full_o,
    output logic [stb_pkg::ROB_TAG_BITS-1:0]         complete_o,
    output logic                                     complete_vld_o,
    // commit pulses from the rob
    input  wire logic                                commit0_i,
    input  wire logic                                commit1_i,
    // load forwarding lookup
    input  wire logic [stb_pkg::WORD_ADDR_BITS-1:0]  ld_addr_i,
    input  wire logic [3:0]                          ld_bm_i,
    output logic                                     ld_hit_o,
    output logic                                     ld_resolvable_o,
    output logic [31:0]                              ld_data_o,
    output logic [3:0]                               ld_bm_o,
    // drain handshake
    input  wire logic                                wr_ack_i,
    output logic                                     wr_req_o,
    output logic [stb_pkg::WORD_ADDR_BITS-1:0]       wr_addr_o,
    output logic [31:0]                              wr_data_o,
    output logic [3:0]                               wr_bm_o,
    // status
    output logic                                     sb_empty_o,
    output logic                                     nonspec_empty_o
);
    localparam int N = stb_pkg::SB_ENTRIES;

    // entry storage, index 0 oldest
    logic [stb_pkg::WORD_ADDR_BITS-1:0] ent_addr [N];
    logic [31:0]                        ent_data [N];
    logic [3:0]                         ent_bm   [N];
    logic [N-1:0]                       ent_io;
    logic [N-1:0]                       vld;
    logic [N-1:0]                       spec;

    // next state after commit, flush, drain and enqueue
    logic [stb_pkg::WORD_ADDR_BITS-1:0] nxt_addr [N];
    logic [31:0]                        nxt_data [N];
    logic [3:0]                         nxt_bm   [N];
    logic [N-1:0]                       nxt_io;
    logic [N-1:0]                       nxt_vld;
    logic [N-1:0]                       nxt_spec;

    logic [N-1:0] first_spec, second_spec, drain_sel, spec_after, keep, match;
    logic         enq_ok, drain_pop, have_nonspec, launch, match_io;
    stb_pkg::drain_state_e state;

    assign enq_full_o     = &vld;
    assign enq_ok         = enq_en_i && !enq_full_o;
    assign complete_vld_o = enq_ok;
    assign complete_o     = enq_rob_i;

    // pickers: first two speculative, oldest non-speculative
    always_comb begin
        first_spec  = '0;
        second_spec = '0;
        drain_sel   = '0;
        for (int i = 0; i < N; i++) begin
            if (vld[i] && spec[i] && first_spec == '0) begin
                first_spec[i] = 1'b1;
            end else if (vld[i] && spec[i] && second_spec == '0) begin
                second_spec[i] = 1'b1;
            end
            if (vld[i] && !spec[i] && drain_sel == '0) begin
                drain_sel[i] = 1'b1;
            end
        end
    end

    assign have_nonspec    = |drain_sel;
    assign nonspec_empty_o = !have_nonspec;
    assign sb_empty_o      = !(|vld);

    // drained entry stays put until popped, so payload is stable under req
    always_comb begin
        wr_addr_o = '0;
        wr_data_o = '0;
        wr_bm_o   = '0;
        for (int i = 0; i < N; i++) begin
            if (drain_sel[i]) begin
                wr_addr_o = ent_addr[i];
                wr_data_o = ent_data[i];
                wr_bm_o   = ent_bm[i];
            end
        end
    end

    // commit clears spec, flush kills what is still spec, ack pops the drained one
    assign drain_pop  = (state == stb_pkg::DR_WAIT_ACK) && wr_ack_i;
    assign spec_after = spec & ~(first_spec & {N{commit0_i | commit1_i}})
                             & ~(second_spec & {N{commit0_i & commit1_i}});
    assign keep = vld & ~(spec_after & {N{flush_i}}) & ~(drain_sel & {N{drain_pop}});

    // collapse survivors toward index 0, then append the new store
    always_comb begin
        int cnt;
        cnt      = 0;
        nxt_addr = ent_addr;
        nxt_data = ent_data;
        nxt_bm   = ent_bm;
        nxt_io   = ent_io;
        nxt_vld  = '0;
        nxt_spec = '0;
        for (int i = 0; i < N; i++) begin
            if (keep[i]) begin
                nxt_addr[cnt] = ent_addr[i];
                nxt_data[cnt] = ent_data[i];
                nxt_bm[cnt]   = ent_bm[i];
                nxt_io[cnt]   = ent_io[i];
                nxt_spec[cnt] = spec_after[i];
                nxt_vld[cnt]  = 1'b1;
                cnt           = cnt + 1;
            end
        end
        if (enq_ok) begin
            nxt_addr[cnt] = enq_addr_i;
            nxt_data[cnt] = enq_data_i;
            nxt_bm[cnt]   = enq_bm_i;
            nxt_io[cnt]   = enq_io_i;
            nxt_spec[cnt] = 1'b1;
            nxt_vld[cnt]  = 1'b1;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        ent_addr <= nxt_addr;
        ent_data <= nxt_data;
        ent_bm   <= nxt_bm;
        ent_io   <= nxt_io;
    end

    // new request only once the previous ack is seen low
    assign launch = have_nonspec && !wr_ack_i;

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            vld      <= '0;
            spec     <= '0;
            state    <= stb_pkg::DR_IDLE;
            wr_req_o <= 1'b0;
        end else begin
            vld  <= nxt_vld;
            spec <= nxt_spec;
            case (state)
                stb_pkg::DR_WAIT_ACK: begin
                    if (wr_ack_i) begin
                        wr_req_o <= 1'b0;
                        state    <= stb_pkg::DR_WAIT_RELEASE;
                    end
                end
                stb_pkg::DR_WAIT_RELEASE: begin
                    if (!wr_ack_i) begin
                        wr_req_o <= launch;
                        state    <= launch ? stb_pkg::DR_WAIT_ACK : stb_pkg::DR_IDLE;
                    end
                end
                default: begin
                    if (launch) begin
                        wr_req_o <= 1'b1;
                        state    <= stb_pkg::DR_WAIT_ACK;
                    end
                end
            endcase
        end
    end

    // forwarding, same word and overlapping bytes
    always_comb begin
        ld_data_o = '0;
        ld_bm_o   = '0;
        match_io  = 1'b0;
        for (int i = 0; i < N; i++) begin
            match[i] = vld[i] && (ent_addr[i] == ld_addr_i) && |(ent_bm[i] & ld_bm_i);
        end
        // walk youngest to oldest so the oldest match wins
        for (int i = N - 1; i >= 0; i--) begin
            if (match[i]) begin
                ld_data_o = ent_data[i];
                ld_bm_o   = ent_bm[i];
                match_io  = ent_io[i];
            end
        end
    end

    assign ld_hit_o = |match;
    // exactly one match and not io
    assign ld_resolvable_o = ld_hit_o && ((match & (match - 1'b1)) == '0) && !match_io;

endmodule

`default_nettype wire

// ==== hdl/cache_write_port.sv ====
// data cache write port model
`timescale 1ns/100ps
`default_nettype none

module cache_write_port (
    input  wire logic                                cpu_clk_i,
    input  wire logic                                reset_i,
    // drain handshake from the store buffer
    input  wire logic                                wr_req_i,
    input  wire logic [stb_pkg::WORD_ADDR_BITS-1:0]  wr_addr_i,
    input  wire logic [31:0]                         wr_data_i,
    input  wire logic [3:0]                          wr_bm_i,
    output logic                                     wr_ack_o,
    // observation read port
    input  wire logic [stb_pkg::MEM_INDEX_BITS-1:0]  mem_rd_addr_i,
    output logic [31:0]                              mem_rd_data_o
);
    localparam int WORDS = 1 << stb_pkg::MEM_INDEX_BITS;

    logic [31:0]                       mem [WORDS];
    logic [stb_pkg::MEM_INDEX_BITS-1:0] wr_idx;
    logic                              do_write;

    // only the low word address bits reach the array
    assign wr_idx = wr_addr_i[stb_pkg::MEM_INDEX_BITS-1:0];

    // write once, on the edge that raises ack
    assign do_write = wr_req_i && !wr_ack_o;

    // ack follows req, one edge behind
    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            wr_ack_o <= 1'b0;
        end else if (do_write) begin
            wr_ack_o <= 1'b1;
        end else if (!wr_req_i) begin
            wr_ack_o <= 1'b0;
        end
    end

    // array model starts from zero after reset
    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            for (int w = 0; w < WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (do_write) begin
            // byte enables from the store mask
            for (int b = 0; b < 4; b++) begin
                if (wr_bm_i[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // combinational read
    assign mem_rd_data_o = mem[mem_rd_addr_i];

endmodule

`default_nettype wire

// ==== hdl/store_path_top.sv ====
// store path top level
`timescale 1ns/100ps
`default_nettype none

module store_path_top (
    input  wire logic                                cpu_clk_i,
    input  wire logic                                reset_i,
    input  wire logic                                flush_i,
    // store issue
    input  wire logic                                st_valid_i,
    input  wire logic [stb_pkg::PHYS_BITS-1:0]       st_addr_i,
    input  wire stb_pkg::store_size_e                st_size_i,
    input  wire logic [31:0]                         st_data_i,
    input  wire logic                                st_io_i,
    input  wire logic [stb_pkg::ROB_TAG_BITS-1:0]    st_rob_i,
    output logic                                     st_ready_o,
    output logic                                     st_fault_o,
    // completion and commit
    output logic [stb_pkg::ROB_TAG_BITS-1:0]         complete_o,
    output logic                                     complete_vld_o,
    input  wire logic                                commit0_i,
    input  wire logic                                commit1_i,
    // load forwarding
    input  wire logic [stb_pkg::WORD_ADDR_BITS-1:0]  ld_addr_i,
    input  wire logic [3:0]                          ld_bm_i,
    output logic                                     ld_hit_o,
    output logic                                     ld_resolvable_o,
    output logic [31:0]                              ld_data_o,
    output logic [3:0]                               ld_bm_o,
    // memory read and status
    input  wire logic [stb_pkg::MEM_INDEX_BITS-1:0]  mem_rd_addr_i,
    output logic [31:0]                              mem_rd_data_o,
    output logic                                     sb_empty_o,
    output logic                                     nonspec_empty_o
);
    // enqueue link
    logic                               enq_en, enq_full, enq_io;
    logic [stb_pkg::WORD_ADDR_BITS-1:0] enq_addr;
    logic [31:0]                        enq_data;
    logic [3:0]                         enq_bm;
    logic [stb_pkg::ROB_TAG_BITS-1:0]   enq_rob;

    // drain link
    logic                               wr_req, wr_ack;
    logic [stb_pkg::WORD_ADDR_BITS-1:0] wr_addr;
    logic [31:0]                        wr_data;
    logic [3:0]                         wr_bm;

    store_issue u_issue (
        .cpu_clk_i, .reset_i, .flush_i,
        .st_valid_i, .st_addr_i, .st_size_i, .st_data_i, .st_io_i, .st_rob_i,
        .st_ready_o, .st_fault_o,
        .enq_full_i (enq_full),
        .enq_en_o   (enq_en),
        .enq_addr_o (enq_addr),
        .enq_data_o (enq_data),
        .enq_bm_o   (enq_bm),
        .enq_io_o   (enq_io),
        .enq_rob_o  (enq_rob)
    );

    store_buffer u_buffer (
        .cpu_clk_i, .reset_i, .flush_i,
        .enq_en_i (enq_en), .enq_addr_i (enq_addr), .enq_data_i (enq_data),
        .enq_bm_i (enq_bm), .enq_io_i (enq_io), .enq_rob_i (enq_rob),
        .enq_full_o (enq_full),
        .complete_o, .complete_vld_o, .commit0_i, .commit1_i,
        .ld_addr_i, .ld_bm_i, .ld_hit_o, .ld_resolvable_o, .ld_data_o, .ld_bm_o,
        .wr_ack_i (wr_ack), .wr_req_o (wr_req),
        .wr_addr_o (wr_addr), .wr_data_o (wr_data), .wr_bm_o (wr_bm),
        .sb_empty_o, .nonspec_empty_o
    );

    cache_write_port u_port (
        .cpu_clk_i, .reset_i,
        .wr_req_i (wr_req), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
        .wr_bm_i (wr_bm), .wr_ack_o (wr_ack),
        .mem_rd_addr_i, .mem_rd_data_o
    );

endmodule

`default_nettype wire

// ==== testbench/store_path_tb.sv ====
// store path testbench
`timescale 1ns/100ps
`default_nettype none

module store_path_tb;

    logic                                 cpu_clk_i;
    logic                                 reset_i;
    logic                                 flush_i;
    logic                                 st_valid_i;
    logic [stb_pkg::PHYS_BITS-1:0]        st_addr_i;
    stb_pkg::store_size_e                 st_size_i;
    logic [31:0]                          st_data_i;
    logic                                 st_io_i;
    logic [stb_pkg::ROB_TAG_BITS-1:0]     st_rob_i;
    logic                                 st_ready_o;
    logic                                 st_fault_o;
    logic [stb_pkg::ROB_TAG_BITS-1:0]     complete_o;
    logic                                 complete_vld_o;
    logic                                 commit0_i;
    logic                                 commit1_i;
    logic [stb_pkg::WORD_ADDR_BITS-1:0]   ld_addr_i;
    logic [3:0]                           ld_bm_i;
    logic                                 ld_hit_o;
    logic                                 ld_resolvable_o;
    logic [31:0]                          ld_data_o;
    logic [3:0]                           ld_bm_o;
    logic [stb_pkg::MEM_INDEX_BITS-1:0]   mem_rd_addr_i;
    logic [31:0]                          mem_rd_data_o;
    logic                                 sb_empty_o;
    logic                                 nonspec_empty_o;

    // rob tags of issued stores still waiting for completion, oldest first
    logic [stb_pkg::ROB_TAG_BITS-1:0]     pending_rob [$];
    string                                cur_name = "reset";
    int                                   cycles = 0;
    int                                   cycle_limit = 0;

    store_path_top dut (.*);

    // 8 ns clock
    initial begin
        cpu_clk_i = 1'b0;
        forever begin
            #4 cpu_clk_i = ~cpu_clk_i;
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            stop_with_failure($sformatf("mismatch %s %s expected %h actual %h",
                                        cur_name, what, exp, act));
        end
    endtask

    // hold valid until the accepting edge, return just after it
    task automatic issue_store(input int size, input logic [31:0] addr, input logic [31:0] data,
                               input logic io, input logic [31:0] rob);
        st_valid_i <= 1'b1;
        st_size_i  <= stb_pkg::store_size_e'(size[1:0]);
        st_addr_i  <= addr;
        st_data_i  <= data;
        st_io_i    <= io;
        st_rob_i   <= rob[stb_pkg::ROB_TAG_BITS-1:0];
        @(negedge cpu_clk_i);
        while (st_ready_o !== 1'b1) begin
            @(negedge cpu_clk_i);
        end
        @(posedge cpu_clk_i);
        st_valid_i <= 1'b0;
    endtask

    // run length guard
    always @(posedge cpu_clk_i) begin
        cycles <= cycles + 1;
        assert (cycle_limit == 0 || cycles <= cycle_limit) else begin
            stop_with_failure($sformatf("timeout, run still busy after %0d cycles", cycles));
        end
    end

    // completions must come back in issue order
    always @(negedge cpu_clk_i) begin
        if (!reset_i && complete_vld_o === 1'b1) begin
            assert (pending_rob.size() > 0) else begin
                stop_with_failure($sformatf("%s completion seen with no store outstanding",
                                            cur_name));
            end
            check_value("complete_o", pending_rob.pop_front(), complete_o);
        end
    end

    initial begin
        string             name;
        string             cmd;
        logic [8*256-1:0]  rest;
        int                fd;
        int                n;
        int                r;
        int                size;
        logic [31:0]       f1, f2, f3, f4, f5, f6;
        // all inputs quiet, reset held
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        st_valid_i    = 1'b0;
        st_addr_i     = '0;
        st_size_i     = stb_pkg::SZ_WORD;
        st_data_i     = '0;
        st_io_i       = 1'b0;
        st_rob_i      = '0;
        commit0_i     = 1'b0;
        commit1_i     = 1'b0;
        ld_addr_i     = '0;
        ld_bm_i       = '0;
        mem_rd_addr_i = '0;
        void'($urandom(94));
        // line count sets the cycle limit
        fd = $fopen("testbench/store_path_tests.txt", "r");
        assert (fd != 0) else stop_with_failure("could not open the test file");
        n = 0;
        while ($fgets(rest, fd) != 0) begin
            n++;
        end
        $fclose(fd);
        cycle_limit = 20 * n + 100;
        fd = $fopen("testbench/store_path_tests.txt", "r");
        repeat (3) @(posedge cpu_clk_i);
        reset_i <= 1'b0;
        while ($fscanf(fd, "%s", name) == 1) begin
            // comment lines
            if (name == "#") begin
                r = $fgets(rest, fd);
                continue;
            end
            r = $fscanf(fd, "%s", cmd);
            cur_name = name;
            // idle gap of 0 to 3 cycles
            repeat ($urandom % 4) @(posedge cpu_clk_i);
            if (cmd == "ST" || cmd == "FAULT") begin
                r = $fscanf(fd, "%h %h %h %h %h", size, f1, f2, f3, f4);
                assert (r == 5) else stop_with_failure("store line has missing fields");
                if (cmd == "ST") begin
                    pending_rob.push_back(f4[stb_pkg::ROB_TAG_BITS-1:0]);
                end
                issue_store(size, f1, f2, f3[0], f4);
                // fault pulse sits in the cycle after the accepting edge
                @(negedge cpu_clk_i);
                check_value("st_fault_o", (cmd == "FAULT"), st_fault_o);
                @(posedge cpu_clk_i);
            end else if (cmd == "COMMIT") begin
                r = $fscanf(fd, "%h", f1);
                assert (r == 1 && (f1 == 1 || f1 == 2)) else begin
                    stop_with_failure("commit count must be 1 or 2");
                end
                commit0_i <= 1'b1;
                commit1_i <= (f1 == 2);
                @(posedge cpu_clk_i);
                commit0_i <= 1'b0;
                commit1_i <= 1'b0;
                // committed store is drainable and still held while req is up
                @(negedge cpu_clk_i);
                check_value("nonspec_empty_o", 0, nonspec_empty_o);
                @(posedge cpu_clk_i);
            end else if (cmd == "FLUSH") begin
                flush_i <= 1'b1;
                @(posedge cpu_clk_i);
                flush_i <= 1'b0;
            end else if (cmd == "LD") begin
                r = $fscanf(fd, "%h %h %h %h %h %h", f1, f2, f3, f4, f5, f6);
                assert (r == 6) else stop_with_failure("load line has missing fields");
                ld_addr_i <= f1[stb_pkg::WORD_ADDR_BITS-1:0];
                ld_bm_i   <= f2[3:0];
                @(negedge cpu_clk_i);
                check_value("ld_hit_o", f3, ld_hit_o);
                check_value("ld_resolvable_o", f4, ld_resolvable_o);
                // payload only means something on a hit
                if (f3 != 0) begin
                    check_value("ld_data_o", f5, ld_data_o);
                    check_value("ld_bm_o", f6, ld_bm_o);
                    // a hit needs some valid entry
                    check_value("sb_empty_o", 0, sb_empty_o);
                end
                @(posedge cpu_clk_i);
            end else if (cmd == "DRAIN") begin
                r = $fscanf(fd, "%h", f1);
                assert (r == 1) else stop_with_failure("drain line has no mode field");
                // 1 waits for an empty buffer, 0 for no committed entry left
                @(negedge cpu_clk_i);
                while (((f1 != 0) ? sb_empty_o : nonspec_empty_o) !== 1'b1) begin
                    @(negedge cpu_clk_i);
                end
                @(posedge cpu_clk_i);
            end else if (cmd == "MEM") begin
                r = $fscanf(fd, "%h %h", f1, f2);
                assert (r == 2) else stop_with_failure("memory line has missing fields");
                mem_rd_addr_i <= f1[stb_pkg::MEM_INDEX_BITS-1:0];
                @(negedge cpu_clk_i);
                check_value($sformatf("mem[%h]", f1[stb_pkg::MEM_INDEX_BITS-1:0]), f2,
                            mem_rd_data_o);
                @(posedge cpu_clk_i);
            end else if (cmd == "READY") begin
                r = $fscanf(fd, "%h", f1);
                assert (r == 1) else stop_with_failure("ready line has no level field");
                @(negedge cpu_clk_i);
                check_value("st_ready_o", f1, st_ready_o);
                @(posedge cpu_clk_i);
            end else begin
                stop_with_failure($sformatf("unknown command %s on line %s", cmd, name));
            end
        end
        $fclose(fd);
        cur_name = "end of run";
        assert (pending_rob.size() == 0) else begin
            stop_with_failure("issued stores never reported completion");
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/stb_pkg.sv
hdl/store_issue.sv
hdl/store_buffer.sv
hdl/cache_write_port.sv
hdl/store_path_top.sv
testbench/store_path_tb.sv

// ==== testbench/store_path_tests.txt ====
# name command fields, every field in hex, size 0 byte 1 half 2 word
# ST/FAULT size addr data io rob | COMMIT n | FLUSH | LD waddr bm hit res data bm | DRAIN all | MEM idx word | READY lvl
wr_word       ST     2 00000010 a1b2c3d4 0 01
wr_word       COMMIT 1
wr_word       DRAIN  1
wr_word       MEM    04 a1b2c3d4
merge_lane    ST     0 00000011 000000ee 0 02
merge_lane    ST     1 00000012 00005566 0 03
merge_lane    COMMIT 2
merge_lane    DRAIN  1
merge_lane    MEM    04 5566eed4
merge_low     ST     0 00000023 0000007f 0 04
merge_low     ST     1 00000020 00001234 0 05
merge_low     COMMIT 1
merge_low     COMMIT 1
merge_low     DRAIN  1
merge_low     MEM    08 7f001234
fwd_none      LD     00000004 f 0 0 00000000 0
fwd_single    ST     2 00000040 11223344 0 06
fwd_single    LD     00000010 f 1 1 11223344 f
fwd_other     LD     00000011 f 0 0 00000000 0
fwd_double    ST     0 00000041 000000aa 0 07
fwd_double    LD     00000010 2 1 0 11223344 f
fwd_disjoint  LD     00000010 1 1 1 11223344 f
fwd_io        ST     2 00000084 cafef00d 1 08
fwd_io        LD     00000021 f 1 0 cafef00d f
fwd_flush     FLUSH
fwd_flush     DRAIN  1
fwd_flush     LD     00000010 f 0 0 00000000 0
fwd_flush     MEM    10 00000000
fwd_flush     MEM    21 00000000
part_flush    ST     2 00000030 aaaa0001 0 09
part_flush    ST     2 00000034 aaaa0002 0 0a
part_flush    ST     2 00000038 aaaa0003 0 0b
part_flush    ST     2 0000003c aaaa0004 0 0c
part_flush    COMMIT 2
part_flush    FLUSH
part_flush    DRAIN  1
part_flush    MEM    0c aaaa0001
part_flush    MEM    0d aaaa0002
part_flush    MEM    0e 00000000
part_flush    MEM    0f 00000000
bad_half      FAULT  1 00000051 0000beef 0 0d
bad_word      FAULT  2 00000052 deadbeef 0 0e
bad_store     DRAIN  1
bad_store     MEM    14 00000000
stall_fill    ST     2 00000080 5a5a0000 0 10
stall_fill    ST     2 00000084 5a5a0010 0 11
stall_fill    ST     2 00000088 5a5a0020 0 12
stall_fill    ST     2 0000008c 5a5a0030 0 13
stall_fill    ST     2 00000090 5a5a0040 0 14
stall_fill    ST     2 00000094 5a5a0050 0 15
stall_fill    ST     2 00000098 5a5a0060 0 16
stall_fill    ST     2 0000009c 5a5a0070 0 17
stall_hold    ST     2 000000a0 5a5a0080 0 18
stall_hold    READY  0
stall_free    COMMIT 1
stall_free    DRAIN  0
stall_free    READY  1
stall_free    MEM    20 5a5a0000
stall_free    LD     00000028 f 1 1 5a5a0080 f
stall_flush   COMMIT 2
stall_flush   COMMIT 2
stall_flush   FLUSH
stall_flush   DRAIN  1
stall_flush   MEM    21 5a5a0010
stall_flush   MEM    24 5a5a0040
stall_flush   MEM    25 00000000
stall_flush   MEM    28 00000000
